// ==== rob_pkg.sv ====
// shared widths, sizes and vector typedefs for the reorder buffer core
`default_nettype none

package rob_pkg;

    localparam int unsigned xlen     = 32;  // data width
    localparam int unsigned rob_len  = 8;   // reorder buffer entries
    localparam int unsigned tag_bits = 3;   // log2 of rob_len
    localparam int unsigned num_regs = 32;  // architectural registers
    localparam int unsigned reg_bits = 5;   // log2 of num_regs

    // data word for results, pcs and operands
    typedef logic [xlen-1:0] word_t;

    // reorder buffer index, also the rename tag
    typedef logic [tag_bits-1:0] rob_tag_t;

    // architectural register index
    typedef logic [reg_bits-1:0] reg_idx_t;

    // hardwired zero, never renamed or written
    localparam reg_idx_t zero_reg = '0;

endpackage

`default_nettype wire

// ==== rob_entry.sv ====
// rob_entry, a single reorder buffer slot with done and mispredict flags
`timescale 1ns/1ns
`default_nettype none

module rob_entry (
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,          // squash drops the slot
    input  logic              alloc,          // dispatch into this slot
    input  rob_pkg::reg_idx_t dest_reg_in,
    input  rob_pkg::word_t    pc_in,
    input  logic              complete,       // result bus hit
    input  rob_pkg::word_t    value_in,
    input  logic              mispredict_in,
    input  logic              release_entry,  // retired from head
    output logic              done,
    output logic              mispredict,
    output rob_pkg::reg_idx_t dest_reg,
    output rob_pkg::word_t    value,
    output rob_pkg::word_t    pc
);

    logic occupied;  // slot allocated and not yet retired

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            occupied   <= 1'b0;
            done       <= 1'b0;
            mispredict <= 1'b0;
        end else if (alloc) begin
            occupied   <= 1'b1;
            done       <= 1'b0;
            mispredict <= 1'b0;  // stale flag from previous owner
        end else if (complete) begin
            done       <= 1'b1;
            mispredict <= mispredict_in;
        end else if (release_entry) begin
            occupied <= 1'b0;
            done     <= 1'b0;
        end
    end

    // instruction payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_reg <= dest_reg_in;
            pc       <= pc_in;
        end
        if (complete)
            value <= value_in;
    end

    // result bus may only target a slot handed out by an earlier dispatch
    a_complete_occupied: assert property (@(posedge clock) disable iff (reset)
        complete |-> occupied)
        else $error("rob_entry: completion for an unallocated slot");

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
// reorder_buffer, head and tail pointers, slot array, in-order retire and squash
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_reg,
    input  rob_pkg::word_t    dispatch_pc,
    input  logic              complete_valid,
    input  rob_pkg::rob_tag_t complete_tag,
    input  rob_pkg::word_t    complete_value,
    input  logic              complete_mispredict,
    output rob_pkg::rob_tag_t dispatch_tag,
    output logic              rob_full,
    output logic              retire_valid,
    output rob_pkg::rob_tag_t retire_tag,
    output rob_pkg::reg_idx_t retire_reg,
    output rob_pkg::word_t    retire_value,
    output rob_pkg::word_t    retire_pc,
    output logic              squash,
    input  rob_pkg::rob_tag_t lookup_tag,
    output logic              lookup_done,
    output rob_pkg::word_t    lookup_value
);

    rob_pkg::rob_tag_t          head;
    rob_pkg::rob_tag_t          tail;
    logic [rob_pkg::tag_bits:0] count;  // one extra bit to tell full from empty

    logic [rob_pkg::rob_len-1:0] alloc;
    logic [rob_pkg::rob_len-1:0] complete;
    logic [rob_pkg::rob_len-1:0] release_vec;
    logic [rob_pkg::rob_len-1:0] entry_done;
    logic [rob_pkg::rob_len-1:0] entry_mispredict;
    rob_pkg::reg_idx_t           entry_reg   [rob_pkg::rob_len];
    rob_pkg::word_t              entry_value [rob_pkg::rob_len];
    rob_pkg::word_t              entry_pc    [rob_pkg::rob_len];

    assign dispatch_tag = tail;  // tag handed out in the dispatch cycle
    assign rob_full     = (count == rob_pkg::rob_len[rob_pkg::tag_bits:0]);

    // oldest entry leaves as soon as its result is in
    assign retire_valid = entry_done[head];
    assign retire_tag   = head;
    assign retire_reg   = entry_reg[head];
    assign retire_value = entry_value[head];
    assign retire_pc    = entry_pc[head];
    assign squash       = retire_valid && entry_mispredict[head];

    // operand forwarding read
    assign lookup_done  = entry_done[lookup_tag];
    assign lookup_value = entry_value[lookup_tag];

    for (genvar i = 0; i < rob_pkg::rob_len; i++) begin : g_slot
        assign alloc[i]       = dispatch_valid && (tail == rob_pkg::rob_tag_t'(i));
        assign complete[i]    = complete_valid && (complete_tag == rob_pkg::rob_tag_t'(i));
        assign release_vec[i] = retire_valid && (head == rob_pkg::rob_tag_t'(i));

        rob_entry u_entry (
            .clock         (clock),
            .reset         (reset),
            .flush         (squash),
            .alloc         (alloc[i]),
            .dest_reg_in   (dispatch_reg),
            .pc_in         (dispatch_pc),
            .complete      (complete[i]),
            .value_in      (complete_value),
            .mispredict_in (complete_mispredict),
            .release_entry (release_vec[i]),
            .done          (entry_done[i]),
            .mispredict    (entry_mispredict[i]),
            .dest_reg      (entry_reg[i]),
            .value         (entry_value[i]),
            .pc            (entry_pc[i])
        );
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            // branch itself retires, everything younger is gone
            head  <= head + 1'b1;
            tail  <= head + 1'b1;
            count <= '0;
        end else begin
            if (retire_valid)
                head <= head + 1'b1;
            if (dispatch_valid)
                tail <= tail + 1'b1;
            case ({dispatch_valid, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    // no back-pressure, so the front end must watch rob_full
    a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !rob_full)
        else $error("reorder_buffer: dispatch while full");

    // a done flag at the head implies a live entry
    a_no_retire_empty: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> (count != '0))
        else $error("reorder_buffer: retire while empty");

endmodule

`default_nettype wire

// ==== map_table.sv ====
// map_table, rename table from architectural register to reorder buffer tag
`timescale 1ns/1ns
`default_nettype none

module map_table (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_reg,
    input  rob_pkg::rob_tag_t dispatch_tag,
    input  logic              retire_valid,
    input  rob_pkg::rob_tag_t retire_tag,
    input  logic              squash,
    input  rob_pkg::reg_idx_t src_reg,
    output logic              src_mapped,
    output rob_pkg::rob_tag_t src_map_tag
);

    logic [rob_pkg::num_regs-1:0] map_valid;
    rob_pkg::rob_tag_t            map_tag [rob_pkg::num_regs];

    // mapping valid flags
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            map_valid <= '0;  // every register back to committed state
        end else begin
            for (int r = 0; r < rob_pkg::num_regs; r++) begin
                if (dispatch_valid && dispatch_reg == rob_pkg::reg_idx_t'(r)
                        && dispatch_reg != rob_pkg::zero_reg) begin
                    map_valid[r] <= 1'b1;  // newest producer wins
                end else if (retire_valid && map_valid[r] && map_tag[r] == retire_tag) begin
                    map_valid[r] <= 1'b0;  // value now in the register file
                end
            end
        end
    end

    // producer tags
    always_ff @(posedge clock) begin
        if (dispatch_valid && dispatch_reg != rob_pkg::zero_reg)
            map_tag[dispatch_reg] <= dispatch_tag;
    end

    assign src_mapped  = map_valid[src_reg];
    assign src_map_tag = map_tag[src_reg];

endmodule

`default_nettype wire

// ==== committed_state.sv ====
// committed register file and source operand resolution
`timescale 1ns/1ns
`default_nettype none

module committed_state (
    input  logic              clock,
    input  logic              reset,
    input  logic              retire_valid,
    input  rob_pkg::reg_idx_t retire_reg,
    input  rob_pkg::word_t    retire_value,
    input  rob_pkg::reg_idx_t src_reg,
    input  logic              src_mapped,
    input  rob_pkg::rob_tag_t src_map_tag,
    input  logic              lookup_done,
    input  rob_pkg::word_t    lookup_value,
    output rob_pkg::rob_tag_t lookup_tag,
    output logic              src_ready,
    output rob_pkg::word_t    src_value,
    output rob_pkg::rob_tag_t src_tag
);

    rob_pkg::word_t regs [rob_pkg::num_regs];
    rob_pkg::word_t committed_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < rob_pkg::num_regs; r++)
                regs[r] <= '0;
        end else if (retire_valid && retire_reg != rob_pkg::zero_reg) begin
            regs[retire_reg] <= retire_value;
        end
    end

    assign committed_value = (src_reg == rob_pkg::zero_reg) ? '0 : regs[src_reg];

    // renamed source asks the buffer whether its producer is done
    assign lookup_tag = src_map_tag;

    always_comb begin
        if (!src_mapped) begin
            src_ready = 1'b1;
            src_value = committed_value;
        end else if (lookup_done) begin
            src_ready = 1'b1;  // forwarded from the buffer
            src_value = lookup_value;
        end else begin
            src_ready = 1'b0;  // wait on src_tag
            src_value = '0;
        end
    end

    assign src_tag = src_map_tag;

    // zero register stays zero even when an instruction targets it
    a_zero_reg_kept: assert property (@(posedge clock) disable iff (reset)
        (retire_valid && retire_reg == rob_pkg::zero_reg) |=> regs[rob_pkg::zero_reg] == '0)
        else $error("committed_state: register zero was written");

endmodule

`default_nettype wire

// ==== rob_core.sv ====
// rob_core, top level joining the reorder buffer, map table and committed state
`timescale 1ns/1ns
`default_nettype none

module rob_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_reg,
    input  rob_pkg::word_t    dispatch_pc,
    input  logic              complete_valid,
    input  rob_pkg::rob_tag_t complete_tag,
    input  rob_pkg::word_t    complete_value,
    input  logic              complete_mispredict,
    input  rob_pkg::reg_idx_t src_reg,
    output rob_pkg::rob_tag_t dispatch_tag,
    output logic              rob_full,
    output logic              retire_valid,
    output rob_pkg::reg_idx_t retire_reg,
    output rob_pkg::word_t    retire_value,
    output rob_pkg::word_t    retire_pc,
    output logic              squash,
    output logic              src_ready,
    output rob_pkg::word_t    src_value,
    output rob_pkg::rob_tag_t src_tag
);

    rob_pkg::rob_tag_t retire_tag;
    rob_pkg::rob_tag_t lookup_tag;
    logic              lookup_done;
    rob_pkg::word_t    lookup_value;
    logic              src_mapped;
    rob_pkg::rob_tag_t src_map_tag;

    reorder_buffer u_reorder_buffer (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_reg        (dispatch_reg),
        .dispatch_pc         (dispatch_pc),
        .complete_valid      (complete_valid),
        .complete_tag        (complete_tag),
        .complete_value      (complete_value),
        .complete_mispredict (complete_mispredict),
        .dispatch_tag        (dispatch_tag),
        .rob_full            (rob_full),
        .retire_valid        (retire_valid),
        .retire_tag          (retire_tag),
        .retire_reg          (retire_reg),
        .retire_value        (retire_value),
        .retire_pc           (retire_pc),
        .squash              (squash),
        .lookup_tag          (lookup_tag),
        .lookup_done         (lookup_done),
        .lookup_value        (lookup_value)
    );

    map_table u_map_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_reg   (dispatch_reg),
        .dispatch_tag   (dispatch_tag),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .squash         (squash),
        .src_reg        (src_reg),
        .src_mapped     (src_mapped),
        .src_map_tag    (src_map_tag)
    );

    // operand view merges both halves
    committed_state u_committed_state (
        .clock        (clock),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_value (retire_value),
        .src_reg      (src_reg),
        .src_mapped   (src_mapped),
        .src_map_tag  (src_map_tag),
        .lookup_done  (lookup_done),
        .lookup_value (lookup_value),
        .lookup_tag   (lookup_tag),
        .src_ready    (src_ready),
        .src_value    (src_value),
        .src_tag      (src_tag)
    );

endmodule

`default_nettype wire

// ==== tb_rob_core.sv ====
// testbench for rob_core with reference model, checking assertions, stimulus and report
`timescale 1ns/1ns
`default_nettype none

module tb_rob_core;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic dispatch_valid = 1'b0;
    rob_pkg::reg_idx_t dispatch_reg = '0;
    rob_pkg::word_t dispatch_pc = '0;
    logic complete_valid = 1'b0;
    rob_pkg::rob_tag_t complete_tag = '0;
    rob_pkg::word_t complete_value = '0;
    logic complete_mispredict = 1'b0;
    rob_pkg::reg_idx_t src_reg = '0;
    rob_pkg::rob_tag_t dispatch_tag;
    logic rob_full;
    logic retire_valid;
    rob_pkg::reg_idx_t retire_reg;
    rob_pkg::word_t retire_value;
    rob_pkg::word_t retire_pc;
    logic squash;
    logic src_ready;
    rob_pkg::word_t src_value;
    rob_pkg::rob_tag_t src_tag;

    // reference model state with one slot per buffer entry
    rob_pkg::reg_idx_t exp_reg [rob_pkg::rob_len];
    rob_pkg::word_t exp_pc [rob_pkg::rob_len];
    rob_pkg::word_t exp_val [rob_pkg::rob_len];
    logic [rob_pkg::rob_len-1:0] exp_done;
    logic [rob_pkg::rob_len-1:0] exp_mp;
    rob_pkg::rob_tag_t exp_head;
    rob_pkg::rob_tag_t exp_tail;
    int exp_count;
    rob_pkg::word_t ref_regs [rob_pkg::num_regs];
    logic exp_retire_valid;
    logic exp_squash;
    logic exp_src_ready;
    rob_pkg::word_t exp_src_value;
    rob_pkg::rob_tag_t exp_src_tag;

    rob_pkg::rob_tag_t inflight_q [$];  // dispatched tags not yet completed
    int seed = 32'hd5e3;
    rob_pkg::word_t next_pc = 32'h100;
    string test_name = "reset";
    int errors = 0;
    int errors_before = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int retired_total = 0;
    int retire_target = 0;

    rob_core u_rob_core (.*);

    always #5 clock = ~clock;

    assign exp_retire_valid = exp_done[exp_head];
    assign exp_squash = exp_retire_valid && exp_mp[exp_head];

    // youngest in-flight writer of src_reg wins over the committed value
    always_comb begin
        rob_pkg::rob_tag_t slot;
        exp_src_ready = 1'b1;
        exp_src_value = ref_regs[src_reg];
        exp_src_tag = '0;
        for (int k = 0; k < rob_pkg::rob_len; k++) begin
            slot = rob_pkg::rob_tag_t'(exp_head + k);
            if (k < exp_count && exp_reg[slot] == src_reg && src_reg != rob_pkg::zero_reg) begin
                exp_src_ready = exp_done[slot];
                exp_src_value = exp_val[slot];
                exp_src_tag = slot;
            end
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            exp_head <= '0;
            exp_tail <= '0;
            exp_count <= 0;
            exp_done <= '0;
            for (int r = 0; r < rob_pkg::num_regs; r++)
                ref_regs[r] <= '0;
        end else begin
            if (exp_retire_valid && exp_reg[exp_head] != rob_pkg::zero_reg)
                ref_regs[exp_reg[exp_head]] <= exp_val[exp_head];
            if (exp_squash) begin
                exp_done <= '0;  // younger work discarded
                exp_head <= exp_head + 1'b1;
                exp_tail <= exp_head + 1'b1;
                exp_count <= 0;
            end else begin
                if (dispatch_valid) begin
                    exp_reg[exp_tail] <= dispatch_reg;
                    exp_pc[exp_tail] <= dispatch_pc;
                    exp_done[exp_tail] <= 1'b0;
                    exp_tail <= exp_tail + 1'b1;
                end
                if (complete_valid) begin
                    exp_val[complete_tag] <= complete_value;
                    exp_mp[complete_tag] <= complete_mispredict;
                    exp_done[complete_tag] <= 1'b1;
                end
                if (exp_retire_valid) begin
                    exp_done[exp_head] <= 1'b0;
                    exp_head <= exp_head + 1'b1;
                end
                exp_count <= exp_count + int'(dispatch_valid) - int'(exp_retire_valid);
            end
        end
        if (!reset && retire_valid)
            retired_total++;
    end

    task automatic report_error(input string field, input rob_pkg::word_t expected,
                                input rob_pkg::word_t actual);
        errors++;
        $display("Error %s %s: expected %h actual %h", test_name, field, expected, actual);
    endtask

    a_retire_valid: assert property (@(posedge clock) disable iff (reset)
        retire_valid == exp_retire_valid)
        else report_error("retire_valid", $sampled(exp_retire_valid), $sampled(retire_valid));
    a_retire_reg: assert property (@(posedge clock) disable iff (reset)
        exp_retire_valid |-> retire_reg == exp_reg[exp_head])
        else report_error("retire_reg", $sampled(exp_reg[exp_head]), $sampled(retire_reg));
    a_retire_value: assert property (@(posedge clock) disable iff (reset)
        exp_retire_valid |-> retire_value == exp_val[exp_head])
        else report_error("retire_value", $sampled(exp_val[exp_head]),
                          $sampled(retire_value));
    a_retire_pc: assert property (@(posedge clock) disable iff (reset)
        exp_retire_valid |-> retire_pc == exp_pc[exp_head])
        else report_error("retire_pc", $sampled(exp_pc[exp_head]), $sampled(retire_pc));
    a_squash: assert property (@(posedge clock) disable iff (reset) squash == exp_squash)
        else report_error("squash", $sampled(exp_squash), $sampled(squash));
    a_rob_full: assert property (@(posedge clock) disable iff (reset)
        rob_full == (exp_count == rob_pkg::rob_len))
        else report_error("rob_full", $sampled(exp_count == rob_pkg::rob_len),
                          $sampled(rob_full));
    a_dispatch_tag: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> dispatch_tag == exp_tail)
        else report_error("dispatch_tag", $sampled(exp_tail), $sampled(dispatch_tag));
    a_src_ready: assert property (@(posedge clock) disable iff (reset)
        src_ready == exp_src_ready)
        else report_error("src_ready", $sampled(exp_src_ready), $sampled(src_ready));
    a_src_value: assert property (@(posedge clock) disable iff (reset)
        exp_src_ready |-> src_value == exp_src_value)
        else report_error("src_value", $sampled(exp_src_value), $sampled(src_value));
    a_src_tag: assert property (@(posedge clock) disable iff (reset)
        !exp_src_ready |-> src_tag == exp_src_tag)
        else report_error("src_tag", $sampled(exp_src_tag), $sampled(src_tag));

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic dispatch(input rob_pkg::reg_idx_t dest);
        dispatch_valid = 1'b1;
        dispatch_reg = dest;
        dispatch_pc = next_pc;
        next_pc = next_pc + 32'd4;
        inflight_q.push_back(dispatch_tag);
        step();
        dispatch_valid = 1'b0;
    endtask

    task automatic complete(input rob_pkg::rob_tag_t tag, input logic mispredict);
        complete_valid = 1'b1;
        complete_tag = tag;
        complete_value = $random(seed);
        complete_mispredict = mispredict;
        retire_target++;
        step();
        complete_valid = 1'b0;
        complete_mispredict = 1'b0;
    endtask

    task automatic complete_random();
        int pick;
        pick = $unsigned($random(seed)) % inflight_q.size();
        complete(inflight_q[pick], 1'b0);
        inflight_q.delete(pick);
    endtask

    task automatic complete_all();
        while (inflight_q.size() > 0)
            complete_random();
    endtask

    task automatic wait_retired();
        int cycles;
        cycles = 0;
        while (retired_total < retire_target && cycles < 100) begin
            step();
            cycles++;
        end
        if (retired_total < retire_target) begin
            errors++;
            $display("%s: timed out waiting for instructions to retire", test_name);
        end
    endtask

    task automatic sweep_regs();
        for (int r = 0; r < rob_pkg::num_regs; r++) begin
            src_reg = rob_pkg::reg_idx_t'(r);
            step();
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_before = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", test_name, errors - errors_before);
        end else begin
            $display("test %s: passed", test_name);
        end
    endtask

    initial begin
        rob_pkg::rob_tag_t branch;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        begin_test("reset");
        step();
        sweep_regs();
        end_test();

        begin_test("in_order_retire");
        repeat (7) dispatch(rob_pkg::reg_idx_t'($random(seed) & 32'h7));
        complete_all();
        wait_retired();
        end_test();

        begin_test("operand");
        src_reg = 5'd9;
        dispatch(5'd9);
        step();  // producer pending with its tag visible
        complete_random();
        step();
        wait_retired();
        step();
        src_reg = rob_pkg::zero_reg;
        dispatch(rob_pkg::zero_reg);
        complete_all();
        wait_retired();
        end_test();

        begin_test("full_flag");
        repeat (8) dispatch(rob_pkg::reg_idx_t'($random(seed) & 32'h7));
        step();
        complete(inflight_q[0], 1'b0);
        inflight_q.delete(0);
        wait_retired();
        step();
        complete_all();
        wait_retired();
        end_test();

        begin_test("squash");
        repeat (5) dispatch(rob_pkg::reg_idx_t'($random(seed) & 32'h7));
        branch = inflight_q[0];
        complete(inflight_q[2], 1'b0);
        complete(inflight_q[3], 1'b0);
        complete(branch, 1'b1);
        retire_target = retire_target - 2;  // younger results never retire
        inflight_q.delete();
        wait_retired();
        sweep_regs();
        dispatch(5'd3);  // tag follows the branch
        complete_all();
        wait_retired();
        end_test();

        begin_test("register_state");
        repeat (24) begin
            if (!rob_full && ($random(seed) & 1))
                dispatch(rob_pkg::reg_idx_t'($random(seed) & 32'h7));
            else if (inflight_q.size() > 0)
                complete_random();
            else
                step();
        end
        complete_all();
        wait_retired();
        sweep_regs();
        end_test();

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rob_pkg.sv
rob_entry.sv
reorder_buffer.sv
map_table.sv
committed_state.sv
rob_core.sv
tb_rob_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rob_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_rob_core \
    -f project.f -o tb_rob_core > build.log 2>&1 \
    && ./obj_dir/tb_rob_core > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
